/* Bender.yml */
package:
  name: ooo_core

sources:
  - include_dirs:
      - design
    files:
      - design/ooo_pkg.sv
      - design/instr_decode.sv
      - design/rename_dispatch.sv
      - design/arch_reg_file.sv
      - design/alu_unit.sv
      - design/reorder_buffer.sv
      - design/ooo_core.sv
  - target: simulation
    include_dirs:
      - design
      - tb
    files:
      - tb/core_tb.sv

/* design/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_cfg.svh"

module alu_unit (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic               exec_valid,
    input  wire ooo_pkg::exec_req_t exec_req,
    output logic                    cmpl_valid,
    output ooo_pkg::cmpl_t          cmpl
);
    import ooo_pkg::*;

    logic [`OOO_XLEN-1:0] result;
    logic [4:0]           shamt;
    logic                 lt;

    assign shamt = exec_req.b[4:0];
    assign lt    = $signed(exec_req.a) < $signed(exec_req.b);

    // b already holds the immediate for I-type ops.
    always_comb begin
        case (exec_req.op)
            OP_ADD, OP_ADDI: result = exec_req.a + exec_req.b;
            OP_SUB:          result = exec_req.a - exec_req.b;
            OP_AND, OP_ANDI: result = exec_req.a & exec_req.b;
            OP_OR, OP_ORI:   result = exec_req.a | exec_req.b;
            OP_XOR, OP_XORI: result = exec_req.a ^ exec_req.b;
            OP_SLL:          result = exec_req.a << shamt;
            OP_SRL:          result = exec_req.a >> shamt;
            OP_SLT, OP_SLTI: result = {{(`OOO_XLEN-1){1'b0}}, lt};
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmpl_valid <= 1'b0;
        end else begin
            cmpl_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            cmpl.tag   <= exec_req.tag;
            cmpl.value <= result;
        end
    end

endmodule

`default_nettype wire

/* design/arch_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_cfg.svh"

module arch_reg_file (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic [`OOO_AREG_W-1:0] rs1,
    input  wire logic [`OOO_AREG_W-1:0] rs2,
    output logic [`OOO_XLEN-1:0]        data1,
    output logic [`OOO_XLEN-1:0]        data2,
    input  wire logic                   we,
    input  wire logic [`OOO_AREG_W-1:0] wr_rd,
    input  wire logic [`OOO_XLEN-1:0]   wr_data
);
    logic [`OOO_XLEN-1:0] regs [`OOO_NUM_AREGS];

    // x0 is never written, so it stays zero.
    assign data1 = regs[rs1];
    assign data2 = regs[rs2];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < `OOO_NUM_AREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (we && wr_rd != '0) begin
            regs[wr_rd] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_cfg.svh"

module instr_decode (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            in_valid,
    output logic                 in_ready,
    input  wire ooo_pkg::instr_u in_instr,
    output logic                 uop_valid,
    input  wire logic            uop_ready,
    output ooo_pkg::uop_t        uop
);
    import ooo_pkg::*;

    alu_op_e dec_op;
    logic    dec_ok;
    logic    dec_imm;
    uop_t    dec_uop;
    logic    accept;

    // opcode, funct3 and funct7 to an alu op.
    always_comb begin
        dec_op  = OP_ADD;
        dec_ok  = 1'b0;
        dec_imm = 1'b0;
        case (in_instr.r.opcode)
            OPC_OP: begin
                dec_ok = (in_instr.r.funct7 == F7_BASE);
                case (in_instr.r.funct3)
                    3'b000: begin
                        if (in_instr.r.funct7 == F7_ALT) begin
                            dec_op = OP_SUB;
                            dec_ok = 1'b1;
                        end else begin
                            dec_op = OP_ADD;
                        end
                    end
                    3'b001:  dec_op = OP_SLL;
                    3'b010:  dec_op = OP_SLT;
                    3'b100:  dec_op = OP_XOR;
                    3'b101:  dec_op = OP_SRL;
                    3'b110:  dec_op = OP_OR;
                    3'b111:  dec_op = OP_AND;
                    default: dec_ok = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec_imm = 1'b1;
                dec_ok  = 1'b1;
                case (in_instr.r.funct3)
                    3'b000:  dec_op = OP_ADDI;
                    3'b010:  dec_op = OP_SLTI;
                    3'b100:  dec_op = OP_XORI;
                    3'b110:  dec_op = OP_ORI;
                    3'b111:  dec_op = OP_ANDI;
                    default: dec_ok = 1'b0;
                endcase
            end
            default: dec_ok = 1'b0;
        endcase
    end

    // rs2 bits belong to the immediate on I-type, so no source there.
    always_comb begin
        dec_uop.op       = dec_op;
        dec_uop.rd       = in_instr.r.rd;
        dec_uop.rs1      = in_instr.r.rs1;
        dec_uop.rs2      = dec_imm ? '0 : in_instr.r.rs2;
        dec_uop.uses_imm = dec_imm;
        dec_uop.imm      = {{(`OOO_XLEN-12){in_instr.i.imm12[11]}}, in_instr.i.imm12};
    end

    assign in_ready = uop_ready | ~uop_valid;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            uop_valid <= 1'b0;
        end else if (accept) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop <= dec_uop;
        end
    end

    a_supported_word: assert property (@(posedge clk) disable iff (!rstn)
        accept |-> dec_ok);

endmodule

`default_nettype wire

/* design/ooo_cfg.svh */
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// datapath width.
`define OOO_XLEN      32

// architectural register space.
`define OOO_NUM_AREGS 32
`define OOO_AREG_W    5

// reorder buffer size, tag is the physical name.
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W     3

`endif

/* design/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_cfg.svh"

module ooo_core (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            in_valid,
    output logic                 in_ready,
    input  wire ooo_pkg::instr_u in_instr,
    output logic                 ret_valid,
    input  wire logic            ret_ready,
    output ooo_pkg::retire_t     ret
);
    import ooo_pkg::*;

    // decode to dispatch.
    logic uop_valid;
    logic uop_ready;
    uop_t uop;

    // dispatch and rob.
    logic                   alloc_en;
    logic [`OOO_AREG_W-1:0] alloc_rd;
    logic [`OOO_TAG_W-1:0]  alloc_tag;
    logic                   rob_full;
    logic [`OOO_TAG_W-1:0]  src1_tag;
    logic [`OOO_TAG_W-1:0]  src2_tag;
    rob_rd_t                src1_rob;
    rob_rd_t                src2_rob;
    logic [`OOO_TAG_W-1:0]  retire_tag;

    // register file ports.
    logic [`OOO_AREG_W-1:0] rf_rs1;
    logic [`OOO_AREG_W-1:0] rf_rs2;
    logic [`OOO_XLEN-1:0]   rf_data1;
    logic [`OOO_XLEN-1:0]   rf_data2;
    logic                   rf_we;
    logic [`OOO_AREG_W-1:0] rf_rd;
    logic [`OOO_XLEN-1:0]   rf_data;

    // execute and completion.
    logic      exec_valid;
    exec_req_t exec_req;
    logic      cmpl_valid;
    cmpl_t     cmpl;

    instr_decode decode_i (.*);

    rename_dispatch dispatch_i (
        .retire_valid (rf_we),
        .*
    );

    arch_reg_file arf_i (
        .clk     (clk),
        .rstn    (rstn),
        .rs1     (rf_rs1),
        .rs2     (rf_rs2),
        .data1   (rf_data1),
        .data2   (rf_data2),
        .we      (rf_we),
        .wr_rd   (rf_rd),
        .wr_data (rf_data)
    );

    alu_unit alu_i (.*);

    reorder_buffer rob_i (.*);

endmodule

`default_nettype wire

/* design/ooo_pkg.sv */
`default_nettype none
`include "ooo_cfg.svh"

package ooo_pkg;

    // major opcodes and funct7 values of the kept subset.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // one instruction word, two encodings.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    typedef struct packed {
        alu_op_e                op;
        logic [`OOO_AREG_W-1:0] rd;
        logic [`OOO_AREG_W-1:0] rs1;
        logic [`OOO_AREG_W-1:0] rs2;
        logic                   uses_imm;
        logic [`OOO_XLEN-1:0]   imm;
    } uop_t;

    typedef struct packed {
        alu_op_e               op;
        logic [`OOO_TAG_W-1:0] tag;
        logic [`OOO_XLEN-1:0]  a;
        logic [`OOO_XLEN-1:0]  b;
    } exec_req_t;

    typedef struct packed {
        logic [`OOO_TAG_W-1:0] tag;
        logic [`OOO_XLEN-1:0]  value;
    } cmpl_t;

    typedef struct packed {
        logic [`OOO_AREG_W-1:0] rd;
        logic [`OOO_XLEN-1:0]   value;
    } retire_t;

    typedef struct packed {
        logic                 done;
        logic [`OOO_XLEN-1:0] value;
    } rob_rd_t;

endpackage

`default_nettype wire

/* design/rename_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_cfg.svh"

module rename_dispatch (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   uop_valid,
    output logic                        uop_ready,
    input  wire ooo_pkg::uop_t          uop,
    output logic                        alloc_en,
    output logic [`OOO_AREG_W-1:0]      alloc_rd,
    input  wire logic [`OOO_TAG_W-1:0]  alloc_tag,
    input  wire logic                   rob_full,
    output logic [`OOO_TAG_W-1:0]       src1_tag,
    output logic [`OOO_TAG_W-1:0]       src2_tag,
    input  wire ooo_pkg::rob_rd_t       src1_rob,
    input  wire ooo_pkg::rob_rd_t       src2_rob,
    output logic [`OOO_AREG_W-1:0]      rf_rs1,
    output logic [`OOO_AREG_W-1:0]      rf_rs2,
    input  wire logic [`OOO_XLEN-1:0]   rf_data1,
    input  wire logic [`OOO_XLEN-1:0]   rf_data2,
    input  wire logic                   retire_valid,
    input  wire logic [`OOO_TAG_W-1:0]  retire_tag,
    output logic                        exec_valid,
    output ooo_pkg::exec_req_t          exec_req
);
    // map table, one entry per architectural register.
    logic [`OOO_NUM_AREGS-1:0] map_valid;
    logic [`OOO_TAG_W-1:0]     map_tag [`OOO_NUM_AREGS];
    logic                      src1_ok;
    logic                      src2_ok;
    logic                      fire;
    logic [`OOO_XLEN-1:0]      opnd_a;
    logic [`OOO_XLEN-1:0]      opnd_b;

    assign src1_tag = map_tag[uop.rs1];
    assign src2_tag = map_tag[uop.rs2];
    assign rf_rs1   = uop.rs1;
    assign rf_rs2   = uop.rs2;

    // unmapped source reads the register file.
    assign src1_ok = !map_valid[uop.rs1] || src1_rob.done;
    assign src2_ok = !map_valid[uop.rs2] || src2_rob.done;

    assign uop_ready = src1_ok && src2_ok && !rob_full;
    assign fire      = uop_valid && uop_ready;

    assign opnd_a = map_valid[uop.rs1] ? src1_rob.value : rf_data1;
    assign opnd_b = uop.uses_imm       ? uop.imm :
                    map_valid[uop.rs2] ? src2_rob.value : rf_data2;

    assign alloc_en   = fire;
    assign alloc_rd   = uop.rd;
    assign exec_valid = fire;

    always_comb begin
        exec_req.op  = uop.op;
        exec_req.tag = alloc_tag;
        exec_req.a   = opnd_a;
        exec_req.b   = opnd_b;
    end

    // retire drops a mapping, a new dispatch to the same rd wins.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            map_valid <= '0;
        end else begin
            for (int r = 0; r < `OOO_NUM_AREGS; r++) begin
                if (retire_valid && map_valid[r] && map_tag[r] == retire_tag) begin
                    map_valid[r] <= 1'b0;
                end
            end
            if (fire && uop.rd != '0) begin
                map_valid[uop.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && uop.rd != '0) begin
            map_tag[uop.rd] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

/* design/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_cfg.svh"

module reorder_buffer (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   alloc_en,
    input  wire logic [`OOO_AREG_W-1:0] alloc_rd,
    output logic [`OOO_TAG_W-1:0]       alloc_tag,
    output logic                        rob_full,
    input  wire logic [`OOO_TAG_W-1:0]  src1_tag,
    input  wire logic [`OOO_TAG_W-1:0]  src2_tag,
    output ooo_pkg::rob_rd_t            src1_rob,
    output ooo_pkg::rob_rd_t            src2_rob,
    input  wire logic                   cmpl_valid,
    input  wire ooo_pkg::cmpl_t         cmpl,
    output logic                        ret_valid,
    input  wire logic                   ret_ready,
    output ooo_pkg::retire_t            ret,
    output logic [`OOO_TAG_W-1:0]       retire_tag,
    output logic                        rf_we,
    output logic [`OOO_AREG_W-1:0]      rf_rd,
    output logic [`OOO_XLEN-1:0]        rf_data
);
    // per-entry state.
    logic [`OOO_ROB_DEPTH-1:0] ent_busy;
    logic [`OOO_ROB_DEPTH-1:0] ent_done;
    logic [`OOO_AREG_W-1:0]    ent_rd  [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0]      ent_val [`OOO_ROB_DEPTH];

    logic [`OOO_TAG_W-1:0] head;
    logic [`OOO_TAG_W-1:0] tail;
    logic [`OOO_TAG_W:0]   count;
    logic                  ret_fire;

    assign alloc_tag = tail;
    assign rob_full  = (count == `OOO_ROB_DEPTH);

    // forwarding reads for dispatch.
    always_comb begin
        src1_rob.done  = ent_busy[src1_tag] & ent_done[src1_tag];
        src1_rob.value = ent_val[src1_tag];
        src2_rob.done  = ent_busy[src2_tag] & ent_done[src2_tag];
        src2_rob.value = ent_val[src2_tag];
    end

    // oldest entry leaves once done.
    assign ret_valid  = ent_busy[head] & ent_done[head];
    assign ret_fire   = ret_valid & ret_ready;
    assign retire_tag = head;

    always_comb begin
        ret.rd    = ent_rd[head];
        ret.value = ent_val[head];
    end

    assign rf_we   = ret_fire;
    assign rf_rd   = ent_rd[head];
    assign rf_data = ent_val[head];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_busy <= '0;
            ent_done <= '0;
        end else begin
            if (alloc_en) begin
                ent_busy[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (cmpl_valid) begin
                ent_done[cmpl.tag] <= 1'b1;
            end
            if (ret_fire) begin
                ent_busy[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            count <= count + (`OOO_TAG_W+1)'(alloc_en) - (`OOO_TAG_W+1)'(ret_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_rd[tail] <= alloc_rd;
        end
        if (cmpl_valid) begin
            ent_val[cmpl.tag] <= cmpl.value;
        end
    end

    a_cmpl_to_busy: assert property (@(posedge clk) disable iff (!rstn)
        cmpl_valid |-> ent_busy[cmpl.tag]);

    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!rstn)
        alloc_en |-> !rob_full);

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
+incdir+tb
design/ooo_pkg.sv
design/instr_decode.sv
design/rename_dispatch.sv
design/arch_reg_file.sv
design/alu_unit.sv
design/reorder_buffer.sv
design/ooo_core.sv
tb/core_tb.sv

/* tb/core_ref_model.svh */
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

    // architectural state in program order.
    logic [`OOO_XLEN-1:0] ref_regs [`OOO_NUM_AREGS];
    retire_t              exp_q [$];

    function automatic void ref_reset();
        for (int r = 0; r < `OOO_NUM_AREGS; r++) begin
            ref_regs[r] = '0;
        end
        exp_q.delete();
    endfunction

    // runs one word and queues the result it has to retire.
    function automatic void ref_execute(input logic [31:0] word);
        logic [6:0]           opcode;
        logic [2:0]           f3;
        logic [4:0]           rd;
        logic [`OOO_XLEN-1:0] a;
        logic [`OOO_XLEN-1:0] b;
        logic [`OOO_XLEN-1:0] res;
        retire_t              item;
        opcode = word[6:0];
        f3     = word[14:12];
        rd     = word[11:7];
        a      = ref_regs[word[19:15]];
        if (opcode == 7'b0010011) begin
            b = {{20{word[31]}}, word[31:20]};
        end else begin
            b = ref_regs[word[24:20]];
        end
        case (f3)
            3'b000:  res = (opcode == 7'b0110011 && word[31:25] == 7'h20) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        // x0 keeps reading zero.
        if (rd != 5'd0) begin
            ref_regs[rd] = res;
        end
        item.rd    = rd;
        item.value = res;
        exp_q.push_back(item);
    endfunction

`endif

/* tb/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_cfg.svh"

module core_tb;
    import ooo_pkg::*;

    localparam int N_INDEP     = 150;
    localparam int N_CHAIN     = 150;
    localparam int N_PRESSURE  = 100;
    localparam int N_TOTAL     = N_INDEP + N_CHAIN + N_PRESSURE;
    localparam int CYCLE_LIMIT = N_TOTAL * 20;
    localparam int IDLE_CYCLES = 8;

    logic    clk;
    logic    rstn;
    logic    in_valid;
    logic    in_ready;
    instr_u  in_instr;
    logic    ret_valid;
    logic    ret_ready;
    retire_t ret;

    logic [31:0] lfsr;
    logic        word_taken;
    logic        saw_stall;
    int          x0_retired;
    int          cycle_count;

    `include "core_ref_model.svh"

    ooo_core dut_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the core stopped retiring", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped on timeout");
        end
    end

    // galois lfsr stepped once per bit.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, want);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped on first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    // random word of the kept subset with registers in lo..hi.
    task automatic make_instr(input int lo, input int hi, output logic [31:0] word);
        logic [31:0] r;
        logic [3:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        take_bits(4, r);
        sel = r[3:0] % 13;
        take_bits(3, r);
        rd = lo + (r % (hi - lo + 1));
        take_bits(3, r);
        rs1 = lo + (r % (hi - lo + 1));
        take_bits(3, r);
        rs2 = lo + (r % (hi - lo + 1));
        take_bits(12, r);
        imm = r[11:0];
        case (sel)
            4'd0:    word = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            4'd1:    word = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            4'd2:    word = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            4'd3:    word = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            4'd4:    word = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            4'd5:    word = {7'h00, rs2, rs1, 3'b001, rd, 7'b0110011};
            4'd6:    word = {7'h00, rs2, rs1, 3'b101, rd, 7'b0110011};
            4'd7:    word = {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
            4'd8:    word = {imm, rs1, 3'b000, rd, 7'b0010011};
            4'd9:    word = {imm, rs1, 3'b111, rd, 7'b0010011};
            4'd10:   word = {imm, rs1, 3'b110, rd, 7'b0010011};
            4'd11:   word = {imm, rs1, 3'b100, rd, 7'b0010011};
            default: word = {imm, rs1, 3'b010, rd, 7'b0010011};
        endcase
    endtask

    // a held word stays until it transfers.
    task automatic drive_step(input int left, input int lo, input int hi, input bit slow_ret);
        logic [31:0] r;
        logic [31:0] word;
        if (word_taken) begin
            in_valid   = 1'b0;
            word_taken = 1'b0;
        end
        if (!in_valid && left > 0) begin
            take_bits(2, r);
            // about one idle cycle in four.
            if (r[1:0] != 2'b00) begin
                make_instr(lo, hi, word);
                in_instr = word;
                in_valid = 1'b1;
            end
        end
        if (slow_ret) begin
            take_bits(4, r);
            ret_ready = (r[3:0] < 4'd5);
        end else begin
            ret_ready = 1'b1;
        end
    endtask

    task automatic sample_step(output bit took);
        retire_t want;
        took = 1'b0;
        if (!in_ready && ret_valid && !ret_ready) begin
            saw_stall = 1'b1;
        end
        if (in_valid && in_ready) begin
            ref_execute(in_instr);
            word_taken = 1'b1;
            took       = 1'b1;
        end
        if (ret_valid && ret_ready) begin
            if (exp_q.size() == 0) begin
                report_failure("a result retired with no instruction outstanding");
            end else begin
                want = exp_q.pop_front();
                check_value("ret.rd", 32'(ret.rd), 32'(want.rd));
                check_value("ret.value", ret.value, want.value);
                if (ret.rd == '0) begin
                    x0_retired = x0_retired + 1;
                end
            end
        end
    endtask

    task automatic run_phase(input int n, input int lo, input int hi, input bit slow_ret);
        int accepted;
        bit took;
        accepted = 0;
        while (accepted < n) begin
            @(posedge clk);
            #1;
            drive_step(n - accepted, lo, hi, slow_ret);
            @(negedge clk);
            sample_step(took);
            if (took) begin
                accepted = accepted + 1;
            end
        end
    endtask

    task automatic drain(input bit slow_ret);
        bit took;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            drive_step(0, 1, 1, slow_ret);
            @(negedge clk);
            sample_step(took);
        end
    endtask

    // an empty core offers nothing more to retire.
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            drive_step(0, 1, 1, 1'b0);
            @(negedge clk);
            check_value("ret_valid", 32'(ret_valid), 32'h0);
            check_value("in_ready", 32'(in_ready), 32'h1);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        ret_ready   = 1'b0;
        lfsr        = 32'd96;
        word_taken  = 1'b0;
        saw_stall   = 1'b0;
        x0_retired  = 0;
        cycle_count = 0;
        ref_reset();
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_value("ret_valid", 32'(ret_valid), 32'h0);
        check_value("in_ready", 32'(in_ready), 32'h1);

        run_phase(N_INDEP, 0, 7, 1'b0);
        // short register range makes dependent chains.
        run_phase(N_CHAIN, 1, 3, 1'b0);
        saw_stall = 1'b0;
        run_phase(N_PRESSURE, 0, 7, 1'b1);
        drain(1'b1);
        check_idle(IDLE_CYCLES);

        if (!saw_stall) begin
            report_failure("in_ready never fell while results waited to retire");
        end
        if (x0_retired == 0) begin
            report_failure("no instruction with rd x0 retired");
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
